/* exec_core.f */
hw/exec_pkg.sv
hw/exec_ctrl_if.sv
hw/issue_fsm.sv
hw/shift_timer.sv
hw/alu.sv
hw/branch_unit.sv
hw/reg_file.sv
hw/exec_core.sv
bench/exec_core_assert.sv
bench/exec_core_tb.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - files:
      - hw/exec_pkg.sv
      - hw/exec_ctrl_if.sv
      - hw/issue_fsm.sv
      - hw/shift_timer.sv
      - hw/alu.sv
      - hw/branch_unit.sv
      - hw/reg_file.sv
      - hw/exec_core.sv
  - target: test
    files:
      - bench/exec_core_assert.sv
      - bench/exec_core_tb.sv

/* bench/exec_core_tb.sv */
`timescale 1ns/10ps
// Fixed-seed random program of 83 instructions; all checking lives in the bound checker
module exec_core_tb import exec_pkg::*; ();

   localparam int N_INSTR = 83;
   localparam int LIMIT   = 20 * N_INSTR + 50;   // Cycle budget for the whole run

   logic              clk = 1'b0;
   logic              reset;
   logic              instr_valid;
   logic              instr_ready;
   logic [DATA_W-1:0] instr;
   logic              done;
   logic              wb_en;
   logic [REG_AW-1:0] wb_reg;
   logic [DATA_W-1:0] wb_data;
   logic [DATA_W-1:0] pc;
   logic              br_taken;
   int                cycles = 0;

   exec_core #(.PC_RESET(16'h0100)) u_dut (.*);

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Timeout, run did not finish within %0d cycles", LIMIT);
      end
   end

   initial begin
      wait (u_dut.u_assert.failed === 1'b1);
      $display("SOME TESTS FAILED");
      $fatal(1, "Checker assertion failed");
   end

   function automatic logic [DATA_W-1:0] rtype_word(alu_fn_e fn, logic [2:0] rd, rs, rt);
      return {OP_RTYPE, rd, rs, rt, fn};
   endfunction

   function automatic logic [DATA_W-1:0] imm_word(opcode_e op, logic [2:0] rd, rs,
                                                  logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic logic [DATA_W-1:0] load_word(logic [2:0] rd, logic [8:0] imm);
      return {OP_LBI, rd, imm};
   endfunction

   function automatic logic [DATA_W-1:0] branch_word(logic [2:0] rs, br_cond_e cond,
                                                     logic [6:0] offset);
      return {OP_BR, rs, cond, offset};
   endfunction

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic send(input logic [DATA_W-1:0] word);
      repeat ($urandom_range(0, 3)) @(negedge clk);   // Idle gap
      instr       = word;
      instr_valid = 1'b1;
      while (!instr_ready)
         @(negedge clk);   // Held while the DUT is busy
      @(negedge clk);
      instr_valid = 1'b0;
   endtask

   initial begin
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      void'($urandom(87));
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      repeat (5) @(negedge clk);
      reset = 1'b0;

      for (int r = 0; r < 8; r++)
         send(load_word(3'(r), 9'($urandom())));
      repeat (40) begin
         rd = 3'($urandom_range(0, 7));
         rs = 3'($urandom_range(0, 7));
         rt = 3'($urandom_range(0, 7));
         case ($urandom_range(0, 5))
            0:       send(rtype_word(FN_ADD, rd, rs, rt));
            1:       send(rtype_word(FN_SUB, rd, rs, rt));
            2:       send(rtype_word(FN_AND, rd, rs, rt));
            3:       send(rtype_word(FN_XOR, rd, rs, rt));
            4:       send(imm_word(OP_ADDI, rd, rs, 6'($urandom())));
            default: send(load_word(rd, 9'($urandom())));
         endcase
      end
      // Every shift amount once, then random ones
      for (int k = 0; k < 20; k++) begin
         rd = 3'($urandom_range(0, 7));
         rs = 3'($urandom_range(0, 7));
         send(imm_word($urandom_range(0, 1) ? OP_SLLI : OP_SRLI, rd, rs,
                       {2'b00, 4'(k < 16 ? k : $urandom())}));
      end
      send(load_word(3'd1, 9'd0));      // Zero
      send(load_word(3'd2, 9'h1fb));    // Negative
      send(load_word(3'd3, 9'd7));      // Positive
      for (int r = 1; r <= 3; r++)
         for (int c = 0; c < 4; c++)
            send(branch_word(3'(r), br_cond_e'(c), 7'($urandom())));

      while (!instr_ready)
         @(negedge clk);
      repeat (2) @(negedge clk);   // Let the last done settle in the checker
      if (u_dut.u_assert.failed) begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Checker assertion failed");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

/* bench/exec_core_assert.sv */
`timescale 1ns/10ps
// Reference model covers the six defined opcodes only; a failed check raises failed for the testbench
module exec_core_assert import exec_pkg::*; #(
   parameter logic [DATA_W-1:0] PC_RESET = '0
) (
   input logic              clk,
   input logic              reset,
   input logic              instr_valid,
   input logic              instr_ready,
   input logic [DATA_W-1:0] instr,
   input logic              done,
   input logic              wb_en,
   input logic [REG_AW-1:0] wb_reg,
   input logic [DATA_W-1:0] wb_data,
   input logic [DATA_W-1:0] pc,
   input logic              br_taken
);

   logic [DATA_W-1:0] shadow [2**REG_AW];   // Architectural registers
   logic [DATA_W-1:0] model_pc;
   instr_u            cur;                  // Instruction in flight
   logic              busy;
   int unsigned       age;                  // Cycles since acceptance
   logic              failed = 1'b0;
   logic [DATA_W-1:0] src;
   logic [DATA_W-1:0] exp_data;
   logic              exp_wen;
   logic              exp_taken;
   logic [DATA_W-1:0] exp_pc;
   int unsigned       exp_lat;

   always_comb begin
      src       = shadow[cur.r_fmt.rs];
      exp_data  = '0;
      exp_wen   = 1'b1;
      exp_taken = 1'b0;
      exp_lat   = 2;
      case (cur.r_fmt.op)
         OP_RTYPE: case (cur.r_fmt.fn)
            FN_ADD:  exp_data = src + shadow[cur.r_fmt.rt];
            FN_SUB:  exp_data = src - shadow[cur.r_fmt.rt];
            FN_AND:  exp_data = src & shadow[cur.r_fmt.rt];
            FN_XOR:  exp_data = src ^ shadow[cur.r_fmt.rt];
            default: exp_wen  = 1'b0;   // Undefined fn retires as a no-op
         endcase
         OP_ADDI: exp_data = src + {{(DATA_W-6){cur.i_fmt.imm[5]}}, cur.i_fmt.imm};
         OP_LBI:  exp_data = {{(DATA_W-9){cur.l_fmt.imm[8]}}, cur.l_fmt.imm};
         OP_SLLI: begin
            exp_data = src << cur.i_fmt.imm[3:0];
            exp_lat  = 2 + cur.i_fmt.imm[3:0];   // One cycle per bit
         end
         OP_SRLI: begin
            exp_data = src >> cur.i_fmt.imm[3:0];
            exp_lat  = 2 + cur.i_fmt.imm[3:0];
         end
         OP_BR: begin
            src     = shadow[cur.b_fmt.rs];
            exp_wen = 1'b0;
            case (cur.b_fmt.cond)
               EQ:      exp_taken = (src == '0);
               NEQ:     exp_taken = (src != '0);
               LT:      exp_taken = src[DATA_W-1];
               default: exp_taken = !src[DATA_W-1];
            endcase
         end
         default: exp_wen = 1'b0;
      endcase
      // Offset is in half-words, counted from the next instruction
      exp_pc = model_pc + DATA_W'(2)
               + (exp_taken ? {{8{cur.b_fmt.offset[6]}}, cur.b_fmt.offset, 1'b0} : '0);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         shadow   <= '{default: '0};
         model_pc <= PC_RESET;
         cur      <= '0;
         busy     <= 1'b0;
         age      <= 0;
      end else begin
         age <= age + 1;
         if (done) begin
            busy     <= 1'b0;
            model_pc <= exp_pc;
            if (exp_wen)
               shadow[cur.r_fmt.rd] <= exp_data;
         end
         if (instr_valid && instr_ready) begin   // Back-to-back accept wins over done
            cur  <= instr;
            busy <= 1'b1;
            age  <= 1;
         end
      end
   end

   a_reset_idle: assert property (@(posedge clk)
      reset |=> instr_ready && !done && !wb_en && pc == PC_RESET) else begin
      $error("Outputs not at their idle values after reset");
      failed = 1'b1;
   end
   a_ready: assert property (@(posedge clk) disable iff (reset)
      instr_ready == (!busy || done)) else begin
      $error("instr_ready out of step with the instruction in flight");
      failed = 1'b1;
   end
   a_done_once: assert property (@(posedge clk) disable iff (reset) done |-> busy) else begin
      $error("done pulsed with no accepted instruction");
      failed = 1'b1;
   end
   a_latency: assert property (@(posedge clk) disable iff (reset) done |-> age == exp_lat)
   else begin
      $error("MISMATCH t=%0t latency exp=%0d got=%0d", $time, $sampled(exp_lat), $sampled(age));
      failed = 1'b1;
   end
   a_wb_en: assert property (@(posedge clk) disable iff (reset) done |-> wb_en == exp_wen)
   else begin
      $error("MISMATCH t=%0t wb_en exp=%0b got=%0b", $time, $sampled(exp_wen), $sampled(wb_en));
      failed = 1'b1;
   end
   a_wb_data: assert property (@(posedge clk) disable iff (reset)
      done && exp_wen |-> wb_data == exp_data && wb_reg == cur.r_fmt.rd) else begin
      $error("MISMATCH t=%0t wb_reg/wb_data exp=%0d/%h got=%0d/%h", $time,
             $sampled(cur.r_fmt.rd), $sampled(exp_data), $sampled(wb_reg), $sampled(wb_data));
      failed = 1'b1;
   end
   a_br_taken: assert property (@(posedge clk) disable iff (reset)
      done |-> br_taken == exp_taken) else begin
      $error("MISMATCH t=%0t br_taken exp=%0b got=%0b", $time, $sampled(exp_taken),
             $sampled(br_taken));
      failed = 1'b1;
   end
   a_pc: assert property (@(posedge clk) disable iff (reset) pc == model_pc) else begin
      $error("MISMATCH t=%0t pc exp=%h got=%h", $time, $sampled(model_pc), $sampled(pc));
      failed = 1'b1;
   end

endmodule

bind exec_core exec_core_assert #(.PC_RESET(PC_RESET)) u_assert (.*);

/* hw/exec_core.sv */
`timescale 1ns/10ps
// Hold instr and instr_valid until accepted; wb_* and br_taken mean something only while done is high
module exec_core import exec_pkg::*; #(
   parameter logic [DATA_W-1:0] PC_RESET = 16'h0000
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              instr_valid,
   output logic              instr_ready,
   input  logic [DATA_W-1:0] instr,
   output logic              done,
   output logic              wb_en,
   output logic [REG_AW-1:0] wb_reg,
   output logic [DATA_W-1:0] wb_data,
   output logic [DATA_W-1:0] pc,
   output logic              br_taken
);

   exec_ctrl_if ctrl_if ();

   logic [DATA_W-1:0] rs_val;
   logic [DATA_W-1:0] rt_val;
   logic [DATA_W-1:0] alu_b;
   logic [DATA_W-1:0] alu_result;

   issue_fsm u_issue_fsm (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .instr       (instr),
      .done        (done),
      .ctrl        (ctrl_if.ctrl)
   );

   shift_timer u_shift_timer (
      .clk   (clk),
      .reset (reset),
      .ctrl  (ctrl_if.dp)
   );

   assign alu_b = ctrl_if.use_imm ? ctrl_if.imm : rt_val;

   alu u_alu (
      .clk    (clk),
      .reset  (reset),
      .a      (rs_val),
      .b      (alu_b),
      .ctrl   (ctrl_if.dp),
      .result (alu_result)
   );

   branch_unit #(
      .PC_RESET (PC_RESET)
   ) u_branch_unit (
      .clk      (clk),
      .reset    (reset),
      .rs_val   (rs_val),
      .ctrl     (ctrl_if.dp),
      .commit   (done),   // PC advances once per instruction
      .pc       (pc),
      .br_taken (br_taken)
   );

   reg_file u_reg_file (
      .clk    (clk),
      .reset  (reset),
      .ctrl   (ctrl_if.dp),
      .wdata  (alu_result),
      .we     (wb_en),
      .rs_val (rs_val),
      .rt_val (rt_val)
   );

   assign wb_en   = done && ctrl_if.wr_en;
   assign wb_reg  = ctrl_if.rd;
   assign wb_data = alu_result;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/10ps
// Reads are combinational with no write bypass; a write lands at the end of the done cycle
module reg_file import exec_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   exec_ctrl_if.dp           ctrl,
   input  logic [DATA_W-1:0] wdata,
   input  logic              we,
   output logic [DATA_W-1:0] rs_val,
   output logic [DATA_W-1:0] rt_val
);

   logic [DATA_W-1:0] regs [2**REG_AW];

   always_ff @(posedge clk) begin
      if (reset)
         regs <= '{default: '0};
      else if (we)
         regs[ctrl.rd] <= wdata;
   end

   assign rs_val = regs[ctrl.rs];
   assign rt_val = regs[ctrl.rt];   // Unused by immediate forms

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/10ps
// PC stays even for an even PC_RESET; the branch offset counts half-words from pc+2
module branch_unit import exec_pkg::*; #(
   parameter logic [DATA_W-1:0] PC_RESET = '0
) (
   input  logic              clk,
   input  logic              reset,
   input  logic [DATA_W-1:0] rs_val,
   exec_ctrl_if.dp           ctrl,
   input  logic              commit,
   output logic [DATA_W-1:0] pc,
   output logic              br_taken
);

   logic              cond_met;
   logic [DATA_W-1:0] pc_inc;
   logic [DATA_W-1:0] br_target;

   // Zero comes from the ALU, which passed rs through
   always_comb begin
      case (ctrl.cond)
         EQ:      cond_met = ctrl.zero;
         NEQ:     cond_met = !ctrl.zero;
         LT:      cond_met = rs_val[DATA_W-1];
         default: cond_met = ctrl.zero || !rs_val[DATA_W-1];   // GTEQ
      endcase
   end

   assign br_taken  = ctrl.is_branch && cond_met;
   assign pc_inc    = pc + DATA_W'(2);
   assign br_target = pc_inc + {ctrl.imm[DATA_W-2:0], 1'b0};

   always_ff @(posedge clk) begin
      if (reset)
         pc <= PC_RESET;
      else if (commit)
         pc <= br_taken ? br_target : pc_inc;
   end

endmodule

/* hw/alu.sv */
`timescale 1ns/10ps
// Result is registered at the end of execute and each shift step; zero follows the registered result
module alu import exec_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  logic [DATA_W-1:0] a,
   input  logic [DATA_W-1:0] b,
   exec_ctrl_if.dp           ctrl,
   output logic [DATA_W-1:0] result
);

   logic [DATA_W-1:0] a_eff;
   logic [DATA_W-1:0] b_eff;
   logic [DATA_W-1:0] sum;
   logic [DATA_W-1:0] comb_out;

   assign a_eff = ctrl.inv_a ? ~a : a;
   assign b_eff = ctrl.inv_b ? ~b : b;
   assign sum   = a_eff + b_eff + DATA_W'(ctrl.cin);   // Carry-out dropped

   always_comb begin
      case (ctrl.alu_op)
         ADD:     comb_out = sum;
         AND:     comb_out = a_eff & b_eff;
         XOR:     comb_out = a_eff ^ b_eff;
         default: comb_out = b_eff;   // PASS
      endcase
   end

   // Doubles as the shift register
   always_ff @(posedge clk) begin
      if (reset) begin
         result <= '0;
      end else if (ctrl.ex_en) begin
         result <= ctrl.shift_start ? a : comb_out;
      end else if (ctrl.sh_step) begin
         if (ctrl.shift_left)
            result <= {result[DATA_W-2:0], 1'b0};
         else
            result <= {1'b0, result[DATA_W-1:1]};   // Logical right
      end
   end

   assign ctrl.zero = (result == '0);

endmodule

/* hw/shift_timer.sv */
`timescale 1ns/10ps
// Shift amounts are 0 to 15; a zero amount finishes in the execute cycle itself
module shift_timer (
   input  logic    clk,
   input  logic    reset,
   exec_ctrl_if.dp ctrl
);

   logic [3:0] cnt;   // Steps still to go, zero when idle

   always_ff @(posedge clk) begin
      if (reset)
         cnt <= '0;
      else if (ctrl.shift_start)
         cnt <= ctrl.shamt;
      else if (cnt != '0)
         cnt <= cnt - 4'd1;
   end

   // Count hits zero at the end of this cycle
   assign ctrl.step_done = ctrl.shift_start ? (ctrl.shamt == '0) : (cnt == 4'd1);

endmodule

/* hw/issue_fsm.sv */
`timescale 1ns/10ps
// One instruction in flight; a new one may be accepted in the write-back cycle
module issue_fsm import exec_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      instr_valid,
   output logic      instr_ready,
   input  instr_u    instr,
   output logic      done,
   exec_ctrl_if.ctrl ctrl
);

   localparam logic [1:0] IDLE  = 2'd0;
   localparam logic [1:0] EXEC  = 2'd1;
   localparam logic [1:0] SHIFT = 2'd2;
   localparam logic [1:0] WB    = 2'd3;

   logic [1:0] state;
   logic [1:0] state_nxt;
   instr_u     instr_q;   // Instruction being executed
   logic       accept;
   logic       is_shift;

   assign instr_ready = (state == IDLE) || (state == WB);
   assign accept      = instr_valid && instr_ready;
   assign done        = (state == WB);

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= IDLE;
         instr_q <= '0;
      end else begin
         state <= state_nxt;
         if (accept)
            instr_q <= instr;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (accept) state_nxt = EXEC;
         EXEC:    state_nxt = (is_shift && !ctrl.step_done) ? SHIFT : WB;
         SHIFT:   if (ctrl.step_done) state_nxt = WB;   // Last step taken this cycle
         WB:      state_nxt = accept ? EXEC : IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   // Decode the view selected by the opcode
   always_comb begin
      ctrl.alu_op     = ADD;
      ctrl.inv_a      = 1'b0;
      ctrl.inv_b      = 1'b0;
      ctrl.cin        = 1'b0;
      ctrl.use_imm    = 1'b0;
      ctrl.imm        = '0;
      ctrl.rs         = instr_q.r_fmt.rs;
      ctrl.rt         = instr_q.r_fmt.rt;
      ctrl.rd         = instr_q.r_fmt.rd;
      ctrl.wr_en      = 1'b0;
      ctrl.is_branch  = 1'b0;
      ctrl.cond       = instr_q.b_fmt.cond;
      ctrl.shift_left = 1'b0;
      ctrl.shamt      = instr_q.i_fmt.imm[3:0];
      is_shift        = 1'b0;
      case (instr_q.r_fmt.op)
         OP_RTYPE: begin
            ctrl.wr_en = 1'b1;
            case (instr_q.r_fmt.fn)
               FN_ADD:  ctrl.alu_op = ADD;
               FN_SUB: begin
                  ctrl.inv_b = 1'b1;   // rs + ~rt + 1
                  ctrl.cin   = 1'b1;
               end
               FN_AND:  ctrl.alu_op = AND;
               FN_XOR:  ctrl.alu_op = XOR;
               default: ctrl.wr_en = 1'b0;
            endcase
         end
         OP_ADDI: begin
            ctrl.use_imm = 1'b1;
            ctrl.imm     = {{(DATA_W-6){instr_q.i_fmt.imm[5]}}, instr_q.i_fmt.imm};
            ctrl.wr_en   = 1'b1;
         end
         OP_LBI: begin
            ctrl.alu_op  = PASS;
            ctrl.use_imm = 1'b1;
            ctrl.imm     = {{(DATA_W-9){instr_q.l_fmt.imm[8]}}, instr_q.l_fmt.imm};
            ctrl.wr_en   = 1'b1;
         end
         OP_SLLI, OP_SRLI: begin
            is_shift        = 1'b1;
            ctrl.shift_left = (instr_q.i_fmt.op == OP_SLLI);
            ctrl.wr_en      = 1'b1;
         end
         OP_BR: begin
            ctrl.rs        = instr_q.b_fmt.rs;
            ctrl.rt        = instr_q.b_fmt.rs;   // ALU passes rs so zero reflects it
            ctrl.alu_op    = PASS;
            ctrl.imm       = {{(DATA_W-7){instr_q.b_fmt.offset[6]}}, instr_q.b_fmt.offset};
            ctrl.is_branch = 1'b1;
         end
         default: ctrl.wr_en = 1'b0;
      endcase
   end

   assign ctrl.ex_en       = (state == EXEC);
   assign ctrl.sh_step     = (state == SHIFT);
   assign ctrl.shift_start = ctrl.ex_en && is_shift;

endmodule

/* hw/exec_ctrl_if.sv */
`timescale 1ns/10ps
// Decoded control is held stable from the execute cycle through write-back; status flows back
interface exec_ctrl_if import exec_pkg::*; ();

   alu_op_e           alu_op;
   logic              inv_a;
   logic              inv_b;
   logic              cin;
   logic              use_imm;   // B operand from imm instead of rt
   logic [DATA_W-1:0] imm;       // Already sign-extended
   logic [REG_AW-1:0] rs;
   logic [REG_AW-1:0] rt;
   logic [REG_AW-1:0] rd;
   logic              wr_en;
   logic              is_branch;
   br_cond_e          cond;
   logic              ex_en;     // Execute cycle
   logic              sh_step;   // One shift step this cycle
   logic              shift_start;
   logic              shift_left;
   logic [3:0]        shamt;

   // Status back to the FSM
   logic              step_done;
   logic              zero;

   modport ctrl (
      output alu_op, inv_a, inv_b, cin, use_imm, imm, rs, rt, rd, wr_en,
      output is_branch, cond, ex_en, sh_step, shift_start, shift_left, shamt,
      input  step_done, zero
   );

   modport dp (
      input  alu_op, inv_a, inv_b, cin, use_imm, imm, rs, rt, rd, wr_en,
      input  is_branch, cond, ex_en, sh_step, shift_start, shift_left, shamt,
      output step_done, zero
   );

endinterface

/* hw/exec_pkg.sv */
// Encodings are fixed by the 16-bit instruction word; opcodes 6 to 15 and fn codes 4 to 7 retire as no-ops
package exec_pkg;

   localparam int DATA_W = 16;   // Datapath and instruction width
   localparam int REG_AW = 3;    // Eight architectural registers

   typedef enum logic [3:0] {
      OP_RTYPE = 4'h0,
      OP_ADDI  = 4'h1,
      OP_LBI   = 4'h2,
      OP_SLLI  = 4'h3,
      OP_SRLI  = 4'h4,
      OP_BR    = 4'h5
   } opcode_e;

   // R-format function field
   typedef enum logic [2:0] {
      FN_ADD = 3'b000,
      FN_SUB = 3'b001,
      FN_AND = 3'b010,
      FN_XOR = 3'b011
   } alu_fn_e;

   typedef enum logic [1:0] {
      EQ   = 2'b00,
      NEQ  = 2'b01,
      LT   = 2'b10,
      GTEQ = 2'b11
   } br_cond_e;

   // Internal ALU operation with SUB folded into ADD
   typedef enum logic [1:0] {
      ADD  = 2'b00,
      AND  = 2'b01,
      XOR  = 2'b10,
      PASS = 2'b11   // B operand straight through
   } alu_op_e;

   // Every view shares op in [15:12]
   typedef union packed {
      struct packed {
         opcode_e           op;
         logic [REG_AW-1:0] rd;
         logic [REG_AW-1:0] rs;
         logic [REG_AW-1:0] rt;
         alu_fn_e           fn;
      } r_fmt;
      struct packed {
         opcode_e            op;
         logic [REG_AW-1:0]  rd;
         logic [REG_AW-1:0]  rs;
         logic signed [5:0]  imm;   // Shift amount in [3:0] for SLLI/SRLI
      } i_fmt;
      struct packed {
         opcode_e            op;
         logic [REG_AW-1:0]  rd;
         logic signed [8:0]  imm;
      } l_fmt;
      struct packed {
         opcode_e            op;
         logic [REG_AW-1:0]  rs;
         br_cond_e           cond;
         logic signed [6:0]  offset;   // In half-words
      } b_fmt;
   } instr_u;

endpackage
